//--- rtl/bus_pkg.sv
package bus_pkg;

    // ####################################################################
    // Widths with a meaning on the bus
    // ####################################################################

    typedef logic [31:0] addr_t;                     // Byte address
    typedef logic [31:0] data_t;                     // Full bus word
    typedef logic [63:0] mtime_t;                    // Machine time and compare
    typedef logic [9:0]  ram_index_t;                // Word index into the RAM

    // ####################################################################
    // Address map
    // ####################################################################

    localparam int unsigned RAM_WORDS = 1024;        // 4 KiB of RAM

    localparam addr_t TIMER_BASE = 32'h0000_8000;
    localparam addr_t TIMER_END  = 32'h0000_800F;

    // Offsets inside the timer window
    localparam addr_t MTIME_LO_OFS    = 32'h0000_0000;
    localparam addr_t MTIME_HI_OFS    = 32'h0000_0004;
    localparam addr_t MTIMECMP_LO_OFS = 32'h0000_0008;
    localparam addr_t MTIMECMP_HI_OFS = 32'h0000_000C;

    typedef enum logic {
        tgt_ram   = 1'b0,
        tgt_timer = 1'b1
    } target_e;

    typedef struct packed {
        logic  start;                                // One-cycle request pulse
        logic  write;                                // High for a store
        addr_t addr;
        data_t wdata;
    } bus_cmd_t;

    typedef struct packed {
        logic  ready;                                // Target can take a start
        data_t rdata;
        logic  rdata_valid;                          // One-cycle read return
    } bus_rsp_t;

endpackage

//--- rtl/bus_ram.sv
`timescale 1ns/100ps

module bus_ram
    import bus_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  bus_cmd_t cmd,
    output bus_rsp_t rsp
);

    data_t      mem [RAM_WORDS];
    ram_index_t index;
    logic       accept;
    logic       busy;
    logic       rdata_valid;
    data_t      rdata;

    assign index  = ram_index_t'(cmd.addr[11:2]);    // Upper bits wrap
    assign accept = cmd.start && !busy;

    // Storage and read data path
    always_ff @(posedge clk) begin
        if (accept) begin
            if (cmd.write) begin
                mem[index] <= cmd.wdata;
            end else begin
                rdata <= mem[index];                 // Old word on a same-edge read
            end
        end
    end

    // ####################################################################
    // Handshake state
    // ####################################################################

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy        <= 1'b0;
            rdata_valid <= 1'b0;
        end else begin
            busy        <= accept;                   // One cycle per access
            rdata_valid <= accept && !cmd.write;
        end
    end

    assign rsp.ready       = !busy;
    assign rsp.rdata       = rdata;
    assign rsp.rdata_valid = rdata_valid;

endmodule

//--- rtl/machine_timer.sv
`timescale 1ns/100ps

module machine_timer
    import bus_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  bus_cmd_t cmd,
    output bus_rsp_t rsp,
    output logic     timer_irq
);

    mtime_t mtime;
    mtime_t mtimecmp;
    logic   accept;
    logic   busy;
    logic   rdata_valid;
    data_t  rdata;
    data_t  read_word;

    assign accept = cmd.start && !busy;

    // Pick the addressed half
    always_comb begin
        case (cmd.addr)
            MTIME_LO_OFS:    read_word = mtime[31:0];
            MTIME_HI_OFS:    read_word = mtime[63:32];
            MTIMECMP_LO_OFS: read_word = mtimecmp[31:0];
            MTIMECMP_HI_OFS: read_word = mtimecmp[63:32];
            default:         read_word = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (accept && !cmd.write) begin
            rdata <= read_word;                      // Value from before the edge
        end
    end

    // ####################################################################
    // Counter, compare register and interrupt
    // ####################################################################

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mtime       <= '0;
            mtimecmp    <= '1;                       // No interrupt until programmed
            timer_irq   <= 1'b0;
            busy        <= 1'b0;
            rdata_valid <= 1'b0;
        end else begin
            mtime       <= mtime + mtime_t'(1);
            timer_irq   <= (mtime >= mtimecmp);
            busy        <= accept;
            rdata_valid <= accept && !cmd.write;
            if (accept && cmd.write) begin
                case (cmd.addr)
                    MTIMECMP_LO_OFS: mtimecmp[31:0]  <= cmd.wdata;
                    MTIMECMP_HI_OFS: mtimecmp[63:32] <= cmd.wdata;
                    default: ;                       // mtime is read only
                endcase
            end
        end
    end

    assign rsp.ready       = !busy;
    assign rsp.rdata       = rdata;
    assign rsp.rdata_valid = rdata_valid;

endmodule

//--- rtl/memory_map_controller.sv
`timescale 1ns/100ps

module memory_map_controller
    import bus_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  bus_cmd_t core_cmd,
    output bus_rsp_t core_rsp,
    output bus_cmd_t ram_cmd,
    input  bus_rsp_t ram_rsp,
    output bus_cmd_t timer_cmd,
    input  bus_rsp_t timer_rsp
);

    logic    is_timer_addr;
    target_e sel;
    target_e rsp_sel;
    logic    accept;

    // ####################################################################
    // Decode and steering
    // ####################################################################

    assign is_timer_addr = (core_cmd.addr >= TIMER_BASE) && (core_cmd.addr <= TIMER_END);
    assign sel           = is_timer_addr ? tgt_timer : tgt_ram;   // Everything else is RAM

    assign ram_cmd.start = core_cmd.start && (sel == tgt_ram);
    assign ram_cmd.write = core_cmd.write && (sel == tgt_ram);
    assign ram_cmd.addr  = core_cmd.addr;                // RAM sits at zero
    assign ram_cmd.wdata = core_cmd.wdata;

    assign timer_cmd.start = core_cmd.start && (sel == tgt_timer);
    assign timer_cmd.write = core_cmd.write && (sel == tgt_timer);
    assign timer_cmd.addr  = core_cmd.addr - TIMER_BASE;
    assign timer_cmd.wdata = core_cmd.wdata;

    // ####################################################################
    // Response selection
    // ####################################################################

    assign core_rsp.ready = (sel == tgt_timer) ? timer_rsp.ready : ram_rsp.ready;
    assign accept         = core_cmd.start && core_rsp.ready;

    // Remember who owes the reply
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rsp_sel <= tgt_ram;
        end else if (accept) begin
            rsp_sel <= sel;
        end
    end

    always_comb begin
        if (rsp_sel == tgt_timer) begin
            core_rsp.rdata       = timer_rsp.rdata;
            core_rsp.rdata_valid = timer_rsp.rdata_valid;
        end else begin
            core_rsp.rdata       = ram_rsp.rdata;
            core_rsp.rdata_valid = ram_rsp.rdata_valid;
        end
    end

endmodule

//--- rtl/bus_subsystem_top.sv
`timescale 1ns/100ps

module bus_subsystem_top
    import bus_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  bus_cmd_t cmd,
    output bus_rsp_t rsp,
    output logic     timer_irq
);

    bus_cmd_t ram_cmd;
    bus_rsp_t ram_rsp;
    bus_cmd_t timer_cmd;
    bus_rsp_t timer_rsp;

    memory_map_controller u_ctrl (
        .clk       (clk),
        .rst_n     (rst_n),
        .core_cmd  (cmd),
        .core_rsp  (rsp),
        .ram_cmd   (ram_cmd),
        .ram_rsp   (ram_rsp),
        .timer_cmd (timer_cmd),
        .timer_rsp (timer_rsp)
    );

    bus_ram u_ram (
        .clk   (clk),
        .rst_n (rst_n),
        .cmd   (ram_cmd),
        .rsp   (ram_rsp)
    );

    machine_timer u_timer (
        .clk       (clk),
        .rst_n     (rst_n),
        .cmd       (timer_cmd),
        .rsp       (timer_rsp),
        .timer_irq (timer_irq)
    );

endmodule

//--- sim/bus_subsystem_properties.sv
`timescale 1ns/100ps

module bus_subsystem_properties
    import bus_pkg::*;
(
    input logic     clk,
    input logic     rst_n,
    input bus_cmd_t cmd,
    input bus_rsp_t rsp,
    input logic     timer_irq,
    input mtime_t   mtimecmp
);

    logic        read_accept;
    int unsigned fail_count = 0;

    assign read_accept = cmd.start && rsp.ready && !cmd.write;

    valid_after_read: assert property (@(posedge clk) disable iff (!rst_n)
        read_accept |=> rsp.rdata_valid)
        else begin
            fail_count = fail_count + 1;
            $error("Read start was not followed by rdata_valid");
        end

    valid_needs_start: assert property (@(posedge clk) disable iff (!rst_n)
        rsp.rdata_valid |-> $past(read_accept))
        else begin
            fail_count = fail_count + 1;
            $error("rdata_valid without an accepted read start");
        end

    ready_after_reset: assert property (@(posedge clk) $rose(rst_n) |-> rsp.ready)
        else begin
            fail_count = fail_count + 1;
            $error("Ready low in the first cycle after reset");
        end

    irq_low_at_max: assert property (@(posedge clk) disable iff (!rst_n)
        (&mtimecmp) |-> !timer_irq)
        else begin
            fail_count = fail_count + 1;
            $error("Timer interrupt high while mtimecmp is all ones");
        end

endmodule

bind bus_subsystem_top bus_subsystem_properties u_props (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd       (cmd),
    .rsp       (rsp),
    .timer_irq (timer_irq),
    .mtimecmp  (u_timer.mtimecmp)
);

//--- sim/tb_bus_subsystem.sv
`timescale 1ns/100ps

module tb_bus_subsystem
    import bus_pkg::*;
;

    localparam int CLK_HALF          = 10;
    localparam int RAND_PAIRS        = 8;
    localparam int CYCLES_PER_TEST   = 10;
    localparam int MARGIN_CYCLES     = 400;     // Directed tests after the table
    localparam int READY_WAIT_CYCLES = 8;
    localparam int VALID_WAIT_CYCLES = 8;
    localparam int IRQ_LEAD          = 40;      // Compare set this far ahead of mtime
    localparam int IRQ_WAIT_CYCLES   = 80;

    typedef enum logic [1:0] {
        chk_none,
        chk_data,
        chk_irq
    } check_e;

    typedef struct {
        string  name;
        logic   write;
        addr_t  addr;
        data_t  wdata;
        check_e kind;
        data_t  expected;
    } test_entry_t;

    logic        clk;
    logic        rst_n;
    bus_cmd_t    cmd;
    bus_rsp_t    rsp;
    logic        timer_irq;

    test_entry_t tests [$];
    data_t       ram_model [RAM_WORDS];
    logic [31:0] lcg_state = 32'd19061;
    int unsigned cycle_count = 0;
    logic        valid_seen = 1'b0;
    data_t       captured_rdata = '0;

    bus_subsystem_top u_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .cmd       (cmd),
        .rsp       (rsp),
        .timer_irq (timer_irq)
    );

    initial clk = 1'b0;
    always #(CLK_HALF) clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        valid_seen  <= rsp.rdata_valid;         // Read return seen in the last cycle
        if (rsp.rdata_valid) begin
            captured_rdata <= rsp.rdata;
        end
    end

    // Failures flagged by the bound assertion checker
    always @(u_dut.u_props.fail_count) begin
        if (u_dut.u_props.fail_count != 0) begin
            stop_on_error("A concurrent assertion failed in the bound checker");
        end
    end

    // ##################################################################
    // Helpers
    // ##################################################################

    function logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    task automatic stop_on_error(input string why);
        $display("%s", why);
        $display("** FAIL **");
        $fatal(1, "Stopped at the first error");
    endtask

    task automatic check_data(input string name, input data_t expected, input data_t actual);
        if (actual !== expected) begin
            stop_on_error($sformatf("Error: %s expected %h actual %h", name, expected, actual));
        end
    endtask

    task automatic check_irq(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            stop_on_error($sformatf("Error: %s expected %b actual %b", name, expected, actual));
        end
    endtask

    task automatic check_ready(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            stop_on_error($sformatf("Error: %s expected %b actual %b", name, expected, actual));
        end
    endtask

    task automatic add_entry(input string name, input logic write, input addr_t addr,
                             input data_t wdata, input check_e kind, input data_t expected);
        test_entry_t e;
        e.name     = name;
        e.write    = write;
        e.addr     = addr;
        e.wdata    = wdata;
        e.kind     = kind;
        e.expected = expected;
        tests.push_back(e);
    endtask

    task automatic add_ram_write(input string name, input addr_t addr, input data_t wdata);
        ram_model[addr[11:2]] = wdata;          // Byte address modulo 4096
        add_entry(name, 1'b1, addr, wdata, chk_none, '0);
    endtask

    task automatic add_ram_read(input string name, input addr_t addr);
        add_entry(name, 1'b0, addr, '0, chk_data, ram_model[addr[11:2]]);
    endtask

    task automatic build_tests();
        addr_t       addrs [RAND_PAIRS];
        logic [31:0] rnd;
        for (int i = 0; i < RAND_PAIRS; i++) begin
            rnd      = next_random();
            addrs[i] = {20'd0, rnd[25:16], 2'b00};
            add_ram_write($sformatf("ram_write_%0d", i), addrs[i], next_random());
        end
        for (int i = 0; i < RAND_PAIRS; i++) begin
            add_ram_read($sformatf("ram_read_%0d", i), addrs[i]);
        end
        add_ram_write("wrap_write", 32'h0000_2004, next_random());
        add_ram_read("wrap_read", 32'h0000_0004);
        add_ram_write("ram_under_timer", 32'h0000_0008, next_random());
        add_entry("cmp_lo_write", 1'b1, TIMER_BASE + MTIMECMP_LO_OFS, 32'hA5A5_0001, chk_none, '0);
        add_entry("cmp_hi_write", 1'b1, TIMER_BASE + MTIMECMP_HI_OFS, 32'hFFFF_0002, chk_none, '0);
        add_entry("cmp_lo_read", 1'b0, TIMER_BASE + MTIMECMP_LO_OFS, '0, chk_data, 32'hA5A5_0001);
        add_entry("cmp_hi_read", 1'b0, TIMER_BASE + MTIMECMP_HI_OFS, '0, chk_data, 32'hFFFF_0002);
        add_ram_read("ram_under_timer_read", 32'h0000_0008);
        add_entry("cmp_lo_max", 1'b1, TIMER_BASE + MTIMECMP_LO_OFS, '1, chk_none, '0);
        add_entry("cmp_hi_max", 1'b1, TIMER_BASE + MTIMECMP_HI_OFS, '1, chk_irq, '0);
    endtask

    // One access; next_addr goes on the bus in the cycle after the start
    task automatic bus_access(input logic write, input addr_t addr, input data_t wdata,
                              input addr_t next_addr, output data_t rdata,
                              output int unsigned start_cycle);
        int waited;
        waited = 0;
        @(negedge clk);
        cmd.start = 1'b0;
        cmd.write = write;
        cmd.addr  = addr;
        cmd.wdata = wdata;
        @(negedge clk);
        while (!rsp.ready) begin
            if (waited == READY_WAIT_CYCLES) begin
                stop_on_error($sformatf("Ready stayed low for address %h", addr));
            end
            waited++;
            @(negedge clk);
        end
        cmd.start   = 1'b1;
        start_cycle = cycle_count;              // Accepted at the next rising edge
        @(negedge clk);
        check_ready($sformatf("ready_after_start_%h", addr), 1'b0, rsp.ready);
        cmd.start = 1'b0;
        cmd.write = 1'b0;
        cmd.addr  = next_addr;
        waited    = 0;
        rdata     = '0;
        if (write) begin
            @(negedge clk);
        end else begin
            do begin
                if (waited == VALID_WAIT_CYCLES) begin
                    stop_on_error($sformatf("No read data returned for address %h", addr));
                end
                waited++;
                @(negedge clk);
            end while (!valid_seen);
            rdata = captured_rdata;
        end
    endtask

    // ##################################################################
    // Directed sequences
    // ##################################################################

    task automatic check_mtime_counting();
        data_t       first;
        data_t       second;
        data_t       third;
        data_t       unused;
        int unsigned c0;
        int unsigned c1;
        int unsigned c2;
        int unsigned cw;
        bus_access(1'b0, TIMER_BASE + MTIME_LO_OFS, '0, '0, first, c0);
        repeat (7) @(negedge clk);
        bus_access(1'b0, TIMER_BASE + MTIME_LO_OFS, '0, '0, second, c1);
        check_data("mtime_count", first + data_t'(c1 - c0), second);
        bus_access(1'b1, TIMER_BASE + MTIME_LO_OFS, 32'h0000_0000, '0, unused, cw);
        bus_access(1'b0, TIMER_BASE + MTIME_LO_OFS, '0, '0, third, c2);
        check_data("mtime_write_ignored", first + data_t'(c2 - c0), third);
    endtask

    task automatic check_interrupt();
        data_t       lo;
        data_t       hi;
        mtime_t      target;
        data_t       unused;
        int unsigned c;
        int          waited;
        bus_access(1'b0, TIMER_BASE + MTIME_LO_OFS, '0, '0, lo, c);
        bus_access(1'b0, TIMER_BASE + MTIME_HI_OFS, '0, '0, hi, c);
        target = {hi, lo} + mtime_t'(IRQ_LEAD);
        bus_access(1'b1, TIMER_BASE + MTIMECMP_LO_OFS, target[31:0], '0, unused, c);
        bus_access(1'b1, TIMER_BASE + MTIMECMP_HI_OFS, target[63:32], '0, unused, c);
        check_irq("irq_low_before_match", 1'b0, timer_irq);
        waited = 0;
        while (!timer_irq) begin
            if (waited == IRQ_WAIT_CYCLES) begin
                stop_on_error("Timer interrupt did not rise after mtimecmp was reached");
            end
            waited++;
            @(negedge clk);
        end
        bus_access(1'b1, TIMER_BASE + MTIMECMP_LO_OFS, '1, '0, unused, c);
        bus_access(1'b1, TIMER_BASE + MTIMECMP_HI_OFS, '1, '0, unused, c);
        check_irq("irq_cleared", 1'b0, timer_irq);
    endtask

    task automatic check_response_routing();
        data_t       rd;
        data_t       word;
        int unsigned c;
        word         = next_random();
        ram_model[4] = word;                    // Byte address 0x10
        bus_access(1'b1, 32'h0000_0010, word, '0, rd, c);
        bus_access(1'b0, TIMER_BASE + MTIMECMP_HI_OFS, '0, 32'h0000_0010, rd, c);
        check_data("route_timer_then_ram", 32'hFFFF_FFFF, rd);
        bus_access(1'b0, 32'h0000_0010, '0, TIMER_BASE + MTIMECMP_LO_OFS, rd, c);
        check_data("route_ram_then_timer", ram_model[4], rd);
    endtask

    initial begin : watchdog
        int limit;
        @(posedge rst_n);
        limit = tests.size() * CYCLES_PER_TEST + MARGIN_CYCLES;
        repeat (limit) @(posedge clk);
        stop_on_error("Timeout: the run hung before all tests finished");
    end

    initial begin : main
        data_t       rd;
        int unsigned c;
        cmd   = '0;
        rst_n = 1'b0;
        build_tests();
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        foreach (tests[i]) begin
            bus_access(tests[i].write, tests[i].addr, tests[i].wdata, tests[i].addr, rd, c);
            case (tests[i].kind)
                chk_data: check_data(tests[i].name, tests[i].expected, rd);
                chk_irq:  check_irq(tests[i].name, tests[i].expected[0], timer_irq);
                default:  ;
            endcase
        end
        check_mtime_counting();
        check_interrupt();
        check_response_routing();
        $display("** PASS **");
        $finish;
    end

endmodule

//--- sources.f
rtl/bus_pkg.sv
rtl/bus_ram.sv
rtl/machine_timer.sv
rtl/memory_map_controller.sv
rtl/bus_subsystem_top.sv
sim/bus_subsystem_properties.sv
sim/tb_bus_subsystem.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        ?= tb_bus_subsystem
FILELIST   ?= sources.f
BUILD_DIR  ?= obj_dir
VFLAGS     ?= --binary --timing --assert
LINT_FLAGS ?= --lint-only -Wall --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
